// File: logic/rv_decode_pkg.sv
package rv_decode_pkg;

   // Major opcodes, instruction bits 6:2
   localparam logic [4:0] OPC_LOAD   = 5'b00000;
   localparam logic [4:0] OPC_OP_IMM = 5'b00100;
   localparam logic [4:0] OPC_AUIPC  = 5'b00101;
   localparam logic [4:0] OPC_STORE  = 5'b01000;
   localparam logic [4:0] OPC_OP     = 5'b01100;
   localparam logic [4:0] OPC_LUI    = 5'b01101;
   localparam logic [4:0] OPC_BRANCH = 5'b11000;
   localparam logic [4:0] OPC_JALR   = 5'b11001;
   localparam logic [4:0] OPC_JAL    = 5'b11011;
   localparam logic [4:0] OPC_SYSTEM = 5'b11100;

   // ALU funct3, shared by immediate and register forms
   localparam logic [2:0] F3_ADD  = 3'b000;
   localparam logic [2:0] F3_SLL  = 3'b001;
   localparam logic [2:0] F3_SLT  = 3'b010;
   localparam logic [2:0] F3_SLTU = 3'b011;
   localparam logic [2:0] F3_XOR  = 3'b100;
   localparam logic [2:0] F3_SR   = 3'b101;
   localparam logic [2:0] F3_OR   = 3'b110;
   localparam logic [2:0] F3_AND  = 3'b111;

   // Memory, branch and jump funct3
   localparam logic [2:0] F3_LB   = 3'b000;
   localparam logic [2:0] F3_LH   = 3'b001;
   localparam logic [2:0] F3_LW   = 3'b010;
   localparam logic [2:0] F3_LBU  = 3'b100;
   localparam logic [2:0] F3_LHU  = 3'b101;
   localparam logic [2:0] F3_SB   = 3'b000;
   localparam logic [2:0] F3_SH   = 3'b001;
   localparam logic [2:0] F3_SW   = 3'b010;
   localparam logic [2:0] F3_BEQ  = 3'b000;
   localparam logic [2:0] F3_BNE  = 3'b001;
   localparam logic [2:0] F3_BLT  = 3'b100;
   localparam logic [2:0] F3_BGE  = 3'b101;
   localparam logic [2:0] F3_BLTU = 3'b110;
   localparam logic [2:0] F3_BGEU = 3'b111;
   localparam logic [2:0] F3_JALR = 3'b000;

   // System funct3
   localparam logic [2:0] F3_PRIV   = 3'b000;
   localparam logic [2:0] F3_CSRRW  = 3'b001;
   localparam logic [2:0] F3_CSRRS  = 3'b010;
   localparam logic [2:0] F3_CSRRC  = 3'b011;
   localparam logic [2:0] F3_CSRRWI = 3'b101;
   localparam logic [2:0] F3_CSRRSI = 3'b110;
   localparam logic [2:0] F3_CSRRCI = 3'b111;

   localparam logic [6:0] F7_BASE = 7'b0000000;
   localparam logic [6:0] F7_ALT  = 7'b0100000;
   localparam logic [6:0] F7_MDU  = 7'b0000001;

   localparam logic [11:0] F12_ECALL  = 12'h000;
   localparam logic [11:0] F12_EBREAK = 12'h001;
   localparam logic [11:0] F12_WFI    = 12'h105;
   localparam logic [11:0] F12_MRET   = 12'h302;

   typedef enum logic [3:0] {
      ALU_ADD    = 4'd0,
      ALU_SUB    = 4'd1,
      ALU_SLL    = 4'd3,
      ALU_SLT    = 4'd4,
      ALU_SLTU   = 4'd5,
      ALU_XOR    = 4'd6,
      ALU_SRL    = 4'd7,
      ALU_SRA    = 4'd8,
      ALU_OR     = 4'd9,
      ALU_AND    = 4'd10,
      ALU_PASS_B = 4'd12
   } alu_op_e;

   // Code 2 stays reserved
   typedef enum logic [1:0] {
      UNIT_ALU = 2'd0,
      UNIT_MDU = 2'd1,
      UNIT_CSR = 2'd3
   } unit_sel_e;

   typedef enum logic [1:0] {
      WB_UNIT_RESULT = 2'd0,
      WB_LOAD_DATA   = 2'd1,
      WB_PC_PLUS4    = 2'd3
   } wb_sel_e;

   typedef enum logic [1:0] {
      CSR_NONE  = 2'd0,
      CSR_WRITE = 2'd1,
      CSR_SET   = 2'd2,
      CSR_CLEAR = 2'd3
   } csr_op_e;

   typedef enum logic [3:0] {
      EXC_ILLEGAL_INSTR = 4'd2,
      EXC_BREAKPOINT    = 4'd3,
      EXC_ECALL_M       = 4'd11
   } exc_code_e;

   typedef struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [4:0] opcode;
   } instr_r_t;

   typedef struct packed {
      logic [11:0] funct12;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [4:0]  opcode;
   } instr_i_t;

   // Instruction bits 31:2
   typedef union packed {
      instr_r_t r;
      instr_i_t i;
   } instr_u;

   typedef struct packed {
      logic       exc_valid;
      exc_code_e  exc_code;
      logic       is_mret;
      unit_sel_e  unit_sel;
      logic       csr_en;
      csr_op_e    csr_op;
      logic       csr_src_imm;
      alu_op_e    alu_op;
      logic       mdu_en;
      logic [2:0] mdu_op;
      logic       rs2_negate;
      logic       reg_wr_en;
      wb_sel_e    wb_sel;
      logic       op1_sel;
      logic       op2_sel;
      logic       is_load;
      logic       is_store;
   } decode_ctrl_t;

endpackage

// File: logic/alu_op_decode.sv
`timescale 1ns/1ps

module alu_op_decode (
   input  rv_decode_pkg::instr_u       instr_i,
   input  logic                        m_ext_en_i,
   output logic                        hit_o,
   output rv_decode_pkg::decode_ctrl_t ctrl_o
);
   import rv_decode_pkg::*;

   logic [6:0] imm_funct7;
   logic       imm_is_shift;

   // ALU operation for funct7 of zero
   function automatic alu_op_e base_alu_op(input logic [2:0] funct3);
      alu_op_e op;
      case (funct3)
         F3_ADD:  op = ALU_ADD;
         F3_SLL:  op = ALU_SLL;
         F3_SLT:  op = ALU_SLT;
         F3_SLTU: op = ALU_SLTU;
         F3_XOR:  op = ALU_XOR;
         F3_SR:   op = ALU_SRL;
         F3_OR:   op = ALU_OR;
         default: op = ALU_AND;
      endcase
      return op;
   endfunction

   // Shift immediates carry a funct7 in the upper immediate bits
   assign imm_funct7   = instr_i.i.funct12[11:5];
   assign imm_is_shift = (instr_i.i.funct3 == F3_SLL) || (instr_i.i.funct3 == F3_SR);

   always_comb begin
      ctrl_o = '0;
      hit_o  = 1'b0;
      case (instr_i.r.opcode)
         OPC_OP_IMM: begin
            if (!imm_is_shift || imm_funct7 == F7_BASE) begin
               hit_o         = 1'b1;
               ctrl_o.alu_op = base_alu_op(instr_i.i.funct3);
            end else if (instr_i.i.funct3 == F3_SR && imm_funct7 == F7_ALT) begin
               hit_o         = 1'b1;
               ctrl_o.alu_op = ALU_SRA;
            end
            ctrl_o.reg_wr_en = hit_o;
            ctrl_o.op2_sel   = hit_o;
         end
         OPC_OP: begin
            case (instr_i.r.funct7)
               F7_BASE: begin
                  hit_o         = 1'b1;
                  ctrl_o.alu_op = base_alu_op(instr_i.r.funct3);
               end
               F7_ALT: begin
                  if (instr_i.r.funct3 == F3_ADD) begin
                     hit_o             = 1'b1;
                     ctrl_o.alu_op     = ALU_SUB;
                     ctrl_o.rs2_negate = 1'b1;
                  end else if (instr_i.r.funct3 == F3_SR) begin
                     hit_o         = 1'b1;
                     ctrl_o.alu_op = ALU_SRA;
                  end
               end
               F7_MDU: begin
                  if (m_ext_en_i) begin
                     hit_o           = 1'b1;
                     ctrl_o.unit_sel = UNIT_MDU;
                     ctrl_o.mdu_en   = 1'b1;
                     ctrl_o.mdu_op   = instr_i.r.funct3;
                  end
               end
               default: ;
            endcase
            ctrl_o.reg_wr_en = hit_o;
         end
         default: ;
      endcase
   end

endmodule

// File: logic/flow_mem_decode.sv
`timescale 1ns/1ps

module flow_mem_decode (
   input  rv_decode_pkg::instr_u       instr_i,
   output logic                        hit_o,
   output rv_decode_pkg::decode_ctrl_t ctrl_o
);
   import rv_decode_pkg::*;

   always_comb begin
      ctrl_o = '0;
      hit_o  = 1'b0;
      case (instr_i.i.opcode)
         OPC_LOAD: begin
            case (instr_i.i.funct3)
               F3_LB, F3_LH, F3_LW, F3_LBU, F3_LHU: begin
                  hit_o            = 1'b1;
                  ctrl_o.reg_wr_en = 1'b1;
                  ctrl_o.wb_sel    = WB_LOAD_DATA;
                  ctrl_o.op2_sel   = 1'b1;
                  ctrl_o.is_load   = 1'b1;
               end
               default: ;
            endcase
         end
         OPC_STORE: begin
            case (instr_i.i.funct3)
               F3_SB, F3_SH, F3_SW: begin
                  hit_o           = 1'b1;
                  ctrl_o.op2_sel  = 1'b1;
                  ctrl_o.is_store = 1'b1;
               end
               default: ;
            endcase
         end
         OPC_BRANCH: begin
            case (instr_i.i.funct3)
               F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU: begin
                  // Target is PC plus offset
                  hit_o          = 1'b1;
                  ctrl_o.op1_sel = 1'b1;
                  ctrl_o.op2_sel = 1'b1;
               end
               default: ;
            endcase
         end
         OPC_LUI: begin
            hit_o            = 1'b1;
            ctrl_o.alu_op    = ALU_PASS_B;
            ctrl_o.reg_wr_en = 1'b1;
            ctrl_o.op2_sel   = 1'b1;
         end
         OPC_AUIPC: begin
            hit_o            = 1'b1;
            ctrl_o.reg_wr_en = 1'b1;
            ctrl_o.op1_sel   = 1'b1;
            ctrl_o.op2_sel   = 1'b1;
         end
         OPC_JAL: begin
            hit_o            = 1'b1;
            ctrl_o.reg_wr_en = 1'b1;
            ctrl_o.wb_sel    = WB_PC_PLUS4;
            ctrl_o.op1_sel   = 1'b1;
            ctrl_o.op2_sel   = 1'b1;
         end
         OPC_JALR: begin
            // Base from rs1, link address written back
            if (instr_i.i.funct3 == F3_JALR) begin
               hit_o            = 1'b1;
               ctrl_o.reg_wr_en = 1'b1;
               ctrl_o.wb_sel    = WB_PC_PLUS4;
               ctrl_o.op2_sel   = 1'b1;
            end
         end
         default: ;
      endcase
   end

endmodule

// File: logic/system_decode.sv
`timescale 1ns/1ps

module system_decode (
   input  rv_decode_pkg::instr_u       instr_i,
   output logic                        hit_o,
   output rv_decode_pkg::decode_ctrl_t ctrl_o
);
   import rv_decode_pkg::*;

   logic priv_regs_zero;

   assign priv_regs_zero = (instr_i.i.rd == 5'd0) && (instr_i.i.rs1 == 5'd0);

   always_comb begin
      ctrl_o = '0;
      hit_o  = 1'b0;
      if (instr_i.i.opcode == OPC_SYSTEM) begin
         case (instr_i.i.funct3)
            F3_CSRRW, F3_CSRRS, F3_CSRRC,
            F3_CSRRWI, F3_CSRRSI, F3_CSRRCI: begin
               hit_o            = 1'b1;
               ctrl_o.unit_sel  = UNIT_CSR;
               ctrl_o.csr_en    = 1'b1;
               // Low funct3 bits already match the csr_op encoding
               ctrl_o.csr_op      = csr_op_e'(instr_i.i.funct3[1:0]);
               ctrl_o.csr_src_imm = instr_i.i.funct3[2];
               ctrl_o.reg_wr_en   = 1'b1;
            end
            F3_PRIV: begin
               if (priv_regs_zero) begin
                  case (instr_i.i.funct12)
                     F12_ECALL: begin
                        hit_o            = 1'b1;
                        ctrl_o.exc_valid = 1'b1;
                        ctrl_o.exc_code  = EXC_ECALL_M;
                     end
                     F12_EBREAK: begin
                        hit_o            = 1'b1;
                        ctrl_o.exc_valid = 1'b1;
                        ctrl_o.exc_code  = EXC_BREAKPOINT;
                     end
                     F12_MRET: begin
                        hit_o          = 1'b1;
                        ctrl_o.is_mret = 1'b1;
                     end
                     // No sleep state here, so WFI retires as a no-op
                     F12_WFI: hit_o = 1'b1;
                     default: ;
                  endcase
               end
            end
            default: ;
         endcase
      end
   end

endmodule

// File: logic/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
   input  logic                        clk_i,
   input  logic                        arst_n_i,
   input  logic                        valid_i,
   input  logic                        alu_hit_i,
   input  logic                        flow_hit_i,
   input  logic                        sys_hit_i,
   input  rv_decode_pkg::decode_ctrl_t alu_ctrl_i,
   input  rv_decode_pkg::decode_ctrl_t flow_ctrl_i,
   input  rv_decode_pkg::decode_ctrl_t sys_ctrl_i,
   output logic                        valid_o,
   output rv_decode_pkg::decode_ctrl_t ctrl_o
);
   import rv_decode_pkg::*;

   logic         any_hit;
   decode_ctrl_t merged_ctrl;
   decode_ctrl_t next_ctrl;

   // Decoders that miss drive zero, so a plain OR merges them
   assign any_hit     = alu_hit_i | flow_hit_i | sys_hit_i;
   assign merged_ctrl = decode_ctrl_t'(alu_ctrl_i | flow_ctrl_i | sys_ctrl_i);

   always_comb begin
      next_ctrl = merged_ctrl;
      if (!any_hit) begin
         next_ctrl           = '0;
         next_ctrl.exc_valid = 1'b1;
         next_ctrl.exc_code  = EXC_ILLEGAL_INSTR;
      end
   end

   // Control holds its last value through bubbles
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         valid_o <= 1'b0;
         ctrl_o  <= '0;
      end else begin
         valid_o <= valid_i;
         if (valid_i) begin
            ctrl_o <= next_ctrl;
         end
      end
   end

endmodule

// File: logic/instr_decoder_top.sv
`timescale 1ns/1ps

module instr_decoder_top (
   input  logic                        clk_i,
   input  logic                        arst_n_i,
   input  logic                        valid_i,
   input  rv_decode_pkg::instr_u       instr_i,
   input  logic                        m_ext_en_i,
   output logic                        valid_o,
   output rv_decode_pkg::decode_ctrl_t ctrl_o
);
   import rv_decode_pkg::*;

   logic         alu_hit;
   logic         flow_hit;
   logic         sys_hit;
   decode_ctrl_t alu_ctrl;
   decode_ctrl_t flow_ctrl;
   decode_ctrl_t sys_ctrl;

   alu_op_decode i_alu_op_decode (
      .instr_i    (instr_i),
      .m_ext_en_i (m_ext_en_i),
      .hit_o      (alu_hit),
      .ctrl_o     (alu_ctrl)
   );

   flow_mem_decode i_flow_mem_decode (
      .instr_i (instr_i),
      .hit_o   (flow_hit),
      .ctrl_o  (flow_ctrl)
   );

   system_decode i_system_decode (
      .instr_i (instr_i),
      .hit_o   (sys_hit),
      .ctrl_o  (sys_ctrl)
   );

   decode_stage i_decode_stage (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .valid_i     (valid_i),
      .alu_hit_i   (alu_hit),
      .flow_hit_i  (flow_hit),
      .sys_hit_i   (sys_hit),
      .alu_ctrl_i  (alu_ctrl),
      .flow_ctrl_i (flow_ctrl),
      .sys_ctrl_i  (sys_ctrl),
      .valid_o     (valid_o),
      .ctrl_o      (ctrl_o)
   );

endmodule

// File: testbench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
   parameter int PERIOD_NS    = 20,
   parameter int RESET_CYCLES = 10
) (
   output logic clk_o,
   output logic arst_n_o
);

   initial begin
      clk_o = 1'b0;
      forever #(PERIOD_NS / 2) clk_o = ~clk_o;
   end

   // Release away from the clock edge
   initial begin
      arst_n_o = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk_o);
      #(PERIOD_NS / 4) arst_n_o = 1'b1;
   end

endmodule

// File: testbench/tb_vectors.svh
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// Columns: instruction word, M-extension enable, expected control
task automatic build_vector_table();
   decode_ctrl_t load_exp;
   decode_ctrl_t store_exp;
   decode_ctrl_t branch_exp;
   decode_ctrl_t mret_exp;
   load_exp   = flow_ctrl(1'b1, WB_LOAD_DATA, 1'b0, 1'b1, 1'b0, ALU_ADD);
   store_exp  = flow_ctrl(1'b0, WB_UNIT_RESULT, 1'b0, 1'b0, 1'b1, ALU_ADD);
   branch_exp = flow_ctrl(1'b0, WB_UNIT_RESULT, 1'b1, 1'b0, 1'b0, ALU_ADD);
   mret_exp         = '0;
   mret_exp.is_mret = 1'b1;

   // Loads, stores, branches
   add_vector(enc_i(12'h004, 5'd2, 3'd0, 5'd1, OPC7_LOAD), 1'b0, load_exp);
   add_vector(enc_i(12'h008, 5'd3, 3'd1, 5'd4, OPC7_LOAD), 1'b0, load_exp);
   add_vector(enc_i(12'hffc, 5'd5, 3'd2, 5'd6, OPC7_LOAD), 1'b1, load_exp);
   add_vector(enc_i(12'h010, 5'd7, 3'd4, 5'd8, OPC7_LOAD), 1'b0, load_exp);
   add_vector(enc_i(12'h012, 5'd9, 3'd5, 5'd10, OPC7_LOAD), 1'b0, load_exp);
   add_vector(enc_i(12'h000, 5'd2, 3'd3, 5'd1, OPC7_LOAD), 1'b0, illegal_ctrl());
   add_vector(enc_i(12'h000, 5'd2, 3'd6, 5'd1, OPC7_LOAD), 1'b0, illegal_ctrl());
   add_vector(enc_r(7'h00, 5'd3, 5'd2, 3'd0, 5'd4, OPC7_STORE), 1'b0, store_exp);
   add_vector(enc_r(7'h01, 5'd3, 5'd2, 3'd1, 5'd4, OPC7_STORE), 1'b0, store_exp);
   add_vector(enc_r(7'h7f, 5'd3, 5'd2, 3'd2, 5'd4, OPC7_STORE), 1'b0, store_exp);
   add_vector(enc_r(7'h00, 5'd3, 5'd2, 3'd3, 5'd4, OPC7_STORE), 1'b0, illegal_ctrl());
   add_vector(enc_r(7'h00, 5'd3, 5'd2, 3'd4, 5'd4, OPC7_STORE), 1'b0, illegal_ctrl());
   add_vector(enc_r(7'h00, 5'd1, 5'd2, 3'd0, 5'd8, OPC7_BRANCH), 1'b0, branch_exp);
   add_vector(enc_r(7'h40, 5'd1, 5'd2, 3'd1, 5'd8, OPC7_BRANCH), 1'b0, branch_exp);
   add_vector(enc_r(7'h00, 5'd1, 5'd2, 3'd4, 5'd8, OPC7_BRANCH), 1'b0, branch_exp);
   add_vector(enc_r(7'h00, 5'd1, 5'd2, 3'd5, 5'd8, OPC7_BRANCH), 1'b0, branch_exp);
   add_vector(enc_r(7'h00, 5'd1, 5'd2, 3'd6, 5'd8, OPC7_BRANCH), 1'b0, branch_exp);
   add_vector(enc_r(7'h00, 5'd1, 5'd2, 3'd7, 5'd8, OPC7_BRANCH), 1'b0, branch_exp);
   add_vector(enc_r(7'h00, 5'd1, 5'd2, 3'd2, 5'd8, OPC7_BRANCH), 1'b0, illegal_ctrl());
   add_vector(enc_r(7'h00, 5'd1, 5'd2, 3'd3, 5'd8, OPC7_BRANCH), 1'b0, illegal_ctrl());

   // Upper immediates and jumps
   add_vector(enc_i(12'habc, 5'd5, 3'd3, 5'd1, OPC7_LUI), 1'b0,
              flow_ctrl(1'b1, WB_UNIT_RESULT, 1'b0, 1'b0, 1'b0, ALU_PASS_B));
   add_vector(enc_i(12'h123, 5'd4, 3'd7, 5'd2, OPC7_AUIPC), 1'b0,
              flow_ctrl(1'b1, WB_UNIT_RESULT, 1'b1, 1'b0, 1'b0, ALU_ADD));
   add_vector(enc_i(12'h7ff, 5'd0, 3'd2, 5'd1, OPC7_JAL), 1'b0,
              flow_ctrl(1'b1, WB_PC_PLUS4, 1'b1, 1'b0, 1'b0, ALU_ADD));
   add_vector(enc_i(12'h010, 5'd6, 3'd0, 5'd1, OPC7_JALR), 1'b0,
              flow_ctrl(1'b1, WB_PC_PLUS4, 1'b0, 1'b0, 1'b0, ALU_ADD));
   add_vector(enc_i(12'h010, 5'd6, 3'd4, 5'd1, OPC7_JALR), 1'b0, illegal_ctrl());

   // Register-immediate arithmetic, including bad shift funct7 and old B encodings
   add_vector(enc_i(12'hfff, 5'd1, 3'd0, 5'd2, OPC7_OP_IMM), 1'b0, alu_ctrl(ALU_ADD, 1'b1, 1'b0));
   add_vector(enc_i(12'h800, 5'd1, 3'd2, 5'd2, OPC7_OP_IMM), 1'b0, alu_ctrl(ALU_SLT, 1'b1, 1'b0));
   add_vector(enc_i(12'h001, 5'd1, 3'd3, 5'd2, OPC7_OP_IMM), 1'b0, alu_ctrl(ALU_SLTU, 1'b1, 1'b0));
   add_vector(enc_i(12'h5a5, 5'd1, 3'd4, 5'd2, OPC7_OP_IMM), 1'b0, alu_ctrl(ALU_XOR, 1'b1, 1'b0));
   add_vector(enc_i(12'h0f0, 5'd1, 3'd6, 5'd2, OPC7_OP_IMM), 1'b0, alu_ctrl(ALU_OR, 1'b1, 1'b0));
   add_vector(enc_i(12'hf0f, 5'd1, 3'd7, 5'd2, OPC7_OP_IMM), 1'b0, alu_ctrl(ALU_AND, 1'b1, 1'b0));
   add_vector(enc_i({7'h00, 5'd3}, 5'd1, 3'd1, 5'd2, OPC7_OP_IMM), 1'b0,
              alu_ctrl(ALU_SLL, 1'b1, 1'b0));
   add_vector(enc_i({7'h00, 5'd7}, 5'd1, 3'd5, 5'd2, OPC7_OP_IMM), 1'b0,
              alu_ctrl(ALU_SRL, 1'b1, 1'b0));
   add_vector(enc_i({7'h20, 5'd7}, 5'd1, 3'd5, 5'd2, OPC7_OP_IMM), 1'b0,
              alu_ctrl(ALU_SRA, 1'b1, 1'b0));
   add_vector(enc_i({7'h20, 5'd3}, 5'd1, 3'd1, 5'd2, OPC7_OP_IMM), 1'b0, illegal_ctrl());
   add_vector(enc_i({7'h01, 5'd3}, 5'd1, 3'd5, 5'd2, OPC7_OP_IMM), 1'b0, illegal_ctrl());
   add_vector(enc_i({7'h30, 5'd0}, 5'd1, 3'd1, 5'd2, OPC7_OP_IMM), 1'b0, illegal_ctrl());
   add_vector(enc_i({7'h14, 5'd4}, 5'd1, 3'd1, 5'd2, OPC7_OP_IMM), 1'b0, illegal_ctrl());

   // Register-register arithmetic
   add_vector(enc_r(7'h00, 5'd3, 5'd2, 3'd0, 5'd1, OPC7_OP), 1'b1, alu_ctrl(ALU_ADD, 1'b0, 1'b0));
   add_vector(enc_r(7'h20, 5'd3, 5'd2, 3'd0, 5'd1, OPC7_OP), 1'b0, alu_ctrl(ALU_SUB, 1'b0, 1'b1));
   add_vector(enc_r(7'h00, 5'd3, 5'd2, 3'd1, 5'd1, OPC7_OP), 1'b0, alu_ctrl(ALU_SLL, 1'b0, 1'b0));
   add_vector(enc_r(7'h00, 5'd3, 5'd2, 3'd2, 5'd1, OPC7_OP), 1'b1, alu_ctrl(ALU_SLT, 1'b0, 1'b0));
   add_vector(enc_r(7'h00, 5'd3, 5'd2, 3'd3, 5'd1, OPC7_OP), 1'b0, alu_ctrl(ALU_SLTU, 1'b0, 1'b0));
   add_vector(enc_r(7'h00, 5'd3, 5'd2, 3'd4, 5'd1, OPC7_OP), 1'b0, alu_ctrl(ALU_XOR, 1'b0, 1'b0));
   add_vector(enc_r(7'h00, 5'd3, 5'd2, 3'd5, 5'd1, OPC7_OP), 1'b0, alu_ctrl(ALU_SRL, 1'b0, 1'b0));
   add_vector(enc_r(7'h20, 5'd3, 5'd2, 3'd5, 5'd1, OPC7_OP), 1'b1, alu_ctrl(ALU_SRA, 1'b0, 1'b0));
   add_vector(enc_r(7'h00, 5'd3, 5'd2, 3'd6, 5'd1, OPC7_OP), 1'b0, alu_ctrl(ALU_OR, 1'b0, 1'b0));
   add_vector(enc_r(7'h00, 5'd3, 5'd2, 3'd7, 5'd1, OPC7_OP), 1'b0, alu_ctrl(ALU_AND, 1'b0, 1'b0));
   add_vector(enc_r(7'h20, 5'd3, 5'd2, 3'd1, 5'd1, OPC7_OP), 1'b0, illegal_ctrl());
   add_vector(enc_r(7'h05, 5'd3, 5'd2, 3'd4, 5'd1, OPC7_OP), 1'b1, illegal_ctrl());
   add_vector(enc_r(7'h20, 5'd3, 5'd2, 3'd7, 5'd1, OPC7_OP), 1'b0, illegal_ctrl());
   add_vector(enc_r(7'h30, 5'd3, 5'd2, 3'd1, 5'd1, OPC7_OP), 1'b1, illegal_ctrl());

   // Each M operation enabled, then the same word disabled
   for (int f = 0; f < 8; f++) begin
      add_vector(enc_r(7'h01, 5'd3, 5'd2, f[2:0], 5'd1, OPC7_OP), 1'b1, mdu_ctrl(f[2:0]));
      add_vector(enc_r(7'h01, 5'd3, 5'd2, f[2:0], 5'd1, OPC7_OP), 1'b0, illegal_ctrl());
   end

   // CSR access and the privileged group
   add_vector(enc_i(12'h300, 5'd2, 3'd1, 5'd1, OPC7_SYSTEM), 1'b0, csr_ctrl(CSR_WRITE, 1'b0));
   add_vector(enc_i(12'h305, 5'd2, 3'd2, 5'd1, OPC7_SYSTEM), 1'b0, csr_ctrl(CSR_SET, 1'b0));
   add_vector(enc_i(12'h341, 5'd2, 3'd3, 5'd0, OPC7_SYSTEM), 1'b0, csr_ctrl(CSR_CLEAR, 1'b0));
   add_vector(enc_i(12'h300, 5'd9, 3'd5, 5'd1, OPC7_SYSTEM), 1'b0, csr_ctrl(CSR_WRITE, 1'b1));
   add_vector(enc_i(12'h304, 5'd8, 3'd6, 5'd1, OPC7_SYSTEM), 1'b0, csr_ctrl(CSR_SET, 1'b1));
   add_vector(enc_i(12'h344, 5'd0, 3'd7, 5'd1, OPC7_SYSTEM), 1'b0, csr_ctrl(CSR_CLEAR, 1'b1));
   add_vector(enc_i(12'h300, 5'd2, 3'd4, 5'd1, OPC7_SYSTEM), 1'b0, illegal_ctrl());
   add_vector(enc_i(12'h000, 5'd0, 3'd0, 5'd0, OPC7_SYSTEM), 1'b0, exc_ctrl(EXC_ECALL_M));
   add_vector(enc_i(12'h001, 5'd0, 3'd0, 5'd0, OPC7_SYSTEM), 1'b0, exc_ctrl(EXC_BREAKPOINT));
   add_vector(enc_i(12'h302, 5'd0, 3'd0, 5'd0, OPC7_SYSTEM), 1'b0, mret_exp);
   add_vector(enc_i(12'h105, 5'd0, 3'd0, 5'd0, OPC7_SYSTEM), 1'b0, '0);
   add_vector(enc_i(12'h000, 5'd0, 3'd0, 5'd1, OPC7_SYSTEM), 1'b0, illegal_ctrl());
   add_vector(enc_i(12'h001, 5'd2, 3'd0, 5'd0, OPC7_SYSTEM), 1'b0, illegal_ctrl());
   add_vector(enc_i(12'h302, 5'd0, 3'd0, 5'd3, OPC7_SYSTEM), 1'b0, illegal_ctrl());
   add_vector(enc_i(12'h102, 5'd0, 3'd0, 5'd0, OPC7_SYSTEM), 1'b0, illegal_ctrl());

   // Opcodes outside the supported set
   add_vector(enc_i(12'h0ff, 5'd0, 3'd0, 5'd0, 7'h0f), 1'b0, illegal_ctrl());
   add_vector(enc_r(7'h08, 5'd3, 5'd2, 3'd2, 5'd1, 7'h2f), 1'b1, illegal_ctrl());
   add_vector(enc_r(7'h00, 5'd3, 5'd2, 3'd0, 5'd1, 7'h3b), 1'b0, illegal_ctrl());
   add_vector(enc_i(12'h000, 5'd0, 3'd0, 5'd0, 7'h0b), 1'b0, illegal_ctrl());
   add_vector(enc_i(12'hfff, 5'd31, 3'd7, 5'd31, 7'h7f), 1'b1, illegal_ctrl());
endtask

`endif

// File: testbench/tb_instr_decoder.sv
`timescale 1ns/1ps

module tb_instr_decoder;
   import rv_decode_pkg::*;

   localparam int CLK_PERIOD   = 20;
   localparam int RESET_CYCLES = 10;
   localparam int DRIVE_DELAY  = 2;
   localparam int MAX_BUBBLE   = 3;

   // Full 7-bit opcodes as they appear in the instruction word
   localparam logic [6:0] OPC7_LOAD   = 7'h03;
   localparam logic [6:0] OPC7_OP_IMM = 7'h13;
   localparam logic [6:0] OPC7_AUIPC  = 7'h17;
   localparam logic [6:0] OPC7_STORE  = 7'h23;
   localparam logic [6:0] OPC7_OP     = 7'h33;
   localparam logic [6:0] OPC7_LUI    = 7'h37;
   localparam logic [6:0] OPC7_BRANCH = 7'h63;
   localparam logic [6:0] OPC7_JALR   = 7'h67;
   localparam logic [6:0] OPC7_JAL    = 7'h6f;
   localparam logic [6:0] OPC7_SYSTEM = 7'h73;

   typedef struct packed {
      logic [31:0]  word;
      logic         m_en;
      decode_ctrl_t exp;
   } vector_t;

   logic         clk;
   logic         arst_n;
   logic         valid;
   instr_u       instr;
   logic         m_ext_en;
   logic         valid_out;
   decode_ctrl_t ctrl_out;

   vector_t      vectors[$];
   int           num_rows = 0;
   int           errors = 0;
   logic         exp_valid = 1'b0;
   decode_ctrl_t exp_ctrl = '0;
   string        check_ctx = "after reset";

   tb_clock_gen #(
      .PERIOD_NS    (CLK_PERIOD),
      .RESET_CYCLES (RESET_CYCLES)
   ) i_clock_gen (
      .clk_o    (clk),
      .arst_n_o (arst_n)
   );

   instr_decoder_top i_dut (
      .clk_i      (clk),
      .arst_n_i   (arst_n),
      .valid_i    (valid),
      .instr_i    (instr),
      .m_ext_en_i (m_ext_en),
      .valid_o    (valid_out),
      .ctrl_o     (ctrl_out)
   );

   function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [6:0] opc);
      return {f7, rs2, rs1, f3, rd, opc};
   endfunction

   function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
      return {imm, rs1, f3, rd, opc};
   endfunction

   function automatic decode_ctrl_t exc_ctrl(input exc_code_e code);
      decode_ctrl_t c;
      c           = '0;
      c.exc_valid = 1'b1;
      c.exc_code  = code;
      return c;
   endfunction

   function automatic decode_ctrl_t illegal_ctrl();
      return exc_ctrl(EXC_ILLEGAL_INSTR);
   endfunction

   function automatic decode_ctrl_t alu_ctrl(input alu_op_e op, input logic imm,
                                             input logic neg);
      decode_ctrl_t c;
      c            = '0;
      c.alu_op     = op;
      c.op2_sel    = imm;
      c.rs2_negate = neg;
      c.reg_wr_en  = 1'b1;
      return c;
   endfunction

   function automatic decode_ctrl_t mdu_ctrl(input logic [2:0] op);
      decode_ctrl_t c;
      c           = '0;
      c.unit_sel  = UNIT_MDU;
      c.mdu_en    = 1'b1;
      c.mdu_op    = op;
      c.reg_wr_en = 1'b1;
      return c;
   endfunction

   // Every memory and flow form takes its immediate on op2
   function automatic decode_ctrl_t flow_ctrl(input logic wr, input wb_sel_e wb, input logic pc,
                                              input logic ld, input logic st,
                                              input alu_op_e op);
      decode_ctrl_t c;
      c           = '0;
      c.reg_wr_en = wr;
      c.wb_sel    = wb;
      c.op1_sel   = pc;
      c.op2_sel   = 1'b1;
      c.is_load   = ld;
      c.is_store  = st;
      c.alu_op    = op;
      return c;
   endfunction

   function automatic decode_ctrl_t csr_ctrl(input csr_op_e op, input logic imm);
      decode_ctrl_t c;
      c             = '0;
      c.unit_sel    = UNIT_CSR;
      c.csr_en      = 1'b1;
      c.csr_op      = op;
      c.csr_src_imm = imm;
      c.reg_wr_en   = 1'b1;
      return c;
   endfunction

   task automatic add_vector(input logic [31:0] word, input logic m_en, input decode_ctrl_t exp);
      vector_t v;
      v.word = word;
      v.m_en = m_en;
      v.exp  = exp;
      vectors.push_back(v);
   endtask

   `include "tb_vectors.svh"

   task automatic check_valid(input logic exp, input logic act);
      if (act !== exp) begin
         errors++;
         $display("FAILED valid_o (%s) expected %h got %h", check_ctx, exp, act);
      end
   endtask

   task automatic show_field(input string name, input logic [3:0] exp, input logic [3:0] act);
      if (act !== exp) begin
         $display("   ctrl_o.%s expected %h got %h", name, exp, act);
      end
   endtask

   task automatic check_ctrl(input decode_ctrl_t exp, input decode_ctrl_t act);
      if (act !== exp) begin
         errors++;
         $display("FAILED ctrl_o (%s) expected %h got %h", check_ctx, exp, act);
         show_field("exc_valid", exp.exc_valid, act.exc_valid);
         show_field("exc_code", exp.exc_code, act.exc_code);
         show_field("is_mret", exp.is_mret, act.is_mret);
         show_field("unit_sel", exp.unit_sel, act.unit_sel);
         show_field("csr_en", exp.csr_en, act.csr_en);
         show_field("csr_op", exp.csr_op, act.csr_op);
         show_field("csr_src_imm", exp.csr_src_imm, act.csr_src_imm);
         show_field("alu_op", exp.alu_op, act.alu_op);
         show_field("mdu_en", exp.mdu_en, act.mdu_en);
         show_field("mdu_op", exp.mdu_op, act.mdu_op);
         show_field("rs2_negate", exp.rs2_negate, act.rs2_negate);
         show_field("reg_wr_en", exp.reg_wr_en, act.reg_wr_en);
         show_field("wb_sel", exp.wb_sel, act.wb_sel);
         show_field("op1_sel", exp.op1_sel, act.op1_sel);
         show_field("op2_sel", exp.op2_sel, act.op2_sel);
         show_field("is_load", exp.is_load, act.is_load);
         show_field("is_store", exp.is_store, act.is_store);
      end
   endtask

   // Registered outputs are stable a short time after the edge
   task automatic next_cycle_check();
      @(posedge clk);
      #DRIVE_DELAY;
      check_valid(exp_valid, valid_out);
      check_ctrl(exp_ctrl, ctrl_out);
   endtask

   task automatic drive_row(input int idx);
      valid     = 1'b1;
      instr     = vectors[idx].word[31:2];
      m_ext_en  = vectors[idx].m_en;
      exp_valid = 1'b1;
      exp_ctrl  = vectors[idx].exp;
      check_ctx = $sformatf("vector %0d, word %h", idx, vectors[idx].word);
   endtask

   // Garbage on instr during a bubble must not reach ctrl_o
   task automatic drive_bubble(input int idx);
      logic [31:0] rnd_word;
      rnd_word  = $urandom();
      valid     = 1'b0;
      instr     = rnd_word[31:2];
      m_ext_en  = rnd_word[0];
      exp_valid = 1'b0;
      check_ctx = $sformatf("bubble after vector %0d", idx);
   endtask

   initial begin : main
      int unsigned seed_draw;
      int          bubbles;
      seed_draw = $urandom(53);
      valid     = 1'b0;
      instr     = '0;
      m_ext_en  = 1'b0;
      build_vector_table();
      num_rows = vectors.size();
      wait (arst_n === 1'b1);
      for (int i = 0; i < num_rows; i++) begin
         next_cycle_check();
         drive_row(i);
         if ($urandom_range(0, 3) == 0) begin
            bubbles = $urandom_range(1, MAX_BUBBLE);
            repeat (bubbles) begin
               next_cycle_check();
               drive_bubble(i);
            end
         end
      end
      next_cycle_check();
      $display("Decode run finished: %0d vectors, %0d errors", num_rows, errors);
      if (errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

   initial begin : watchdog
      wait (num_rows > 0);
      #((4 * num_rows + num_rows * MAX_BUBBLE + RESET_CYCLES) * CLK_PERIOD);
      $display("Timeout: the vector loop did not finish, %0d errors so far", errors);
      $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

// File: flist.f
+incdir+testbench
logic/rv_decode_pkg.sv
logic/alu_op_decode.sv
logic/flow_mem_decode.sv
logic/system_decode.sv
logic/decode_stage.sv
logic/instr_decoder_top.sv
testbench/tb_clock_gen.sv
testbench/tb_instr_decoder.sv

// File: Bender.yml
package:
  name: instr_decoder

sources:
  - logic/rv_decode_pkg.sv
  - logic/alu_op_decode.sv
  - logic/flow_mem_decode.sv
  - logic/system_decode.sv
  - logic/decode_stage.sv
  - logic/instr_decoder_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_clock_gen.sv
      - testbench/tb_instr_decoder.sv
